/* source/prf_defines.svh */
//////////////////////////////////////////////////
// size and width constants of the register file
// PRF_TAG_W has to stay equal to clog2 of PRF_SIZE
// the zero tag has to be a valid index below PRF_SIZE
//////////////////////////////////////////////////

`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// number of physical entries
`define PRF_SIZE 64

// bits needed to address one entry
`define PRF_TAG_W 6

// width of one register value
`define PRF_DATA_W 64

// entry that always reads as zero, never handed out by rename
`define PRF_ZERO_TAG 48

`endif

/* source/prf_pkg.sv */
//////////////////////////////////////////////////
// shared types of the register file
// widths come from the defines header
//////////////////////////////////////////////////

`default_nettype none

`include "prf_defines.svh"

package prf_pkg;

	// physical entry index, also what an operand port returns while not ready
	typedef logic [`PRF_TAG_W-1:0] prf_tag_t;

	typedef logic [`PRF_DATA_W-1:0] prf_data_t;	// one register value

	// one bit per entry, used for free, write and allocate masks
	typedef logic [`PRF_SIZE-1:0] prf_vec_t;

	// life cycle of an entry
	// free goes to pending on allocation, pending goes to ready on a result write
	// any state goes back to free on retire or flush
	typedef enum logic [1:0]
	{
		PRF_FREE    = 2'b00,	// on the free list
		PRF_PENDING = 2'b01,	// renamed, result not yet written
		PRF_READY   = 2'b10	// holds a valid value
	} prf_entry_state_e;

endpackage

`default_nettype wire

/* source/prf_write_decode.sv */
//////////////////////////////////////////////////
// decodes result writes and frees per entry
// cdb2 wins over cdb1 on the same tag
// flush list only counts while flush_valid is high
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf_write_decode (
	input  wire logic                                    cdb1_valid,
	input  wire prf_pkg::prf_tag_t                       cdb1_tag,
	input  wire prf_pkg::prf_data_t                      cdb1_data,
	input  wire logic                                    cdb2_valid,
	input  wire prf_pkg::prf_tag_t                       cdb2_tag,
	input  wire prf_pkg::prf_data_t                      cdb2_data,
	input  wire logic                                    free1_valid,	// retire free port 1
	input  wire prf_pkg::prf_tag_t                       free1_idx,
	input  wire logic                                    free2_valid,	// retire free port 2
	input  wire prf_pkg::prf_tag_t                       free2_idx,
	input  wire logic                                    flush_valid,	// branch mispredict strobe
	input  wire prf_pkg::prf_vec_t                       flush_free_list,
	output      prf_pkg::prf_vec_t                       write_en,
	output      prf_pkg::prf_data_t [`PRF_SIZE-1:0]      write_data,
	output      prf_pkg::prf_vec_t                       free_en
);

	//////////////////////////////////////////////////
	// result bus decode
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			write_en[i]   = 1'b0;
			write_data[i] = cdb1_data;	// default source, only looked at when write_en is set
			if (cdb1_valid && (cdb1_tag == prf_pkg::prf_tag_t'(i)))
				write_en[i] = 1'b1;
			// the second bus is checked last so it overrides a shared tag
			if (cdb2_valid && (cdb2_tag == prf_pkg::prf_tag_t'(i)))
			begin
				write_en[i]   = 1'b1;
				write_data[i] = cdb2_data;
			end
		end
	end

	//////////////////////////////////////////////////
	// free decode
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			free_en[i] = (free1_valid && (free1_idx == prf_pkg::prf_tag_t'(i))) ||
			             (free2_valid && (free2_idx == prf_pkg::prf_tag_t'(i)));
		end
		// on a mispredict every listed entry goes back to the free pool
		if (flush_valid)
			free_en = free_en | flush_free_list;
	end

endmodule

`default_nettype wire

/* source/prf_entry_array.sv */
//////////////////////////////////////////////////
// state and data of every physical entry
// priority per entry is free, then allocate, then write
// a write only lands on a pending entry
// the zero tag entry is pinned ready at zero
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf_entry_array (
	input  wire logic                                      clock,
	input  wire logic                                      rst_n,
	input  wire prf_pkg::prf_vec_t                         alloc_en,	// one bit per granted entry
	input  wire prf_pkg::prf_vec_t                         write_en,
	input  wire prf_pkg::prf_data_t [`PRF_SIZE-1:0]        write_data,
	input  wire prf_pkg::prf_vec_t                         free_en,
	output      prf_pkg::prf_entry_state_e [`PRF_SIZE-1:0] entry_state,
	output      prf_pkg::prf_data_t [`PRF_SIZE-1:0]        entry_data
);

	prf_pkg::prf_vec_t take_write;	// result write accepted this cycle

	// a write is dropped when the entry is not pending or when a free or an allocation
	// hits the same entry in the same cycle
	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			take_write[i] = write_en[i] && !free_en[i] && !alloc_en[i] &&
			                (entry_state[i] == prf_pkg::PRF_PENDING);
		end
	end

	//////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (i == `PRF_ZERO_TAG)
				entry_state[i] <= prf_pkg::PRF_READY;	// ignores reset and every request
			else if (!rst_n)
				entry_state[i] <= prf_pkg::PRF_FREE;
			else if (free_en[i])
				entry_state[i] <= prf_pkg::PRF_FREE;	// retire or flush beats everything
			else if (alloc_en[i])
				entry_state[i] <= prf_pkg::PRF_PENDING;
			else if (take_write[i])
				entry_state[i] <= prf_pkg::PRF_READY;
		end
	end

	//////////////////////////////////////////////////
	// entry data
	//////////////////////////////////////////////////

	// values are only looked at when the entry is ready, so they start unknown
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (i == `PRF_ZERO_TAG)
				entry_data[i] <= '0;	// settles during the reset cycles
			else if (take_write[i])
				entry_data[i] <= write_data[i];
		end
	end

endmodule

`default_nettype wire

/* source/prf_free_list.sv */
//////////////////////////////////////////////////
// picks up to two free entries for rename
// a lone request always gets the lowest free entry
// a double request with one entry left gets nothing
// and raises prf_full
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf_free_list (
	input  wire prf_pkg::prf_entry_state_e [`PRF_SIZE-1:0] entry_state,
	input  wire logic                                      alloc_req1,
	input  wire logic                                      alloc_req2,
	output      prf_pkg::prf_vec_t                         alloc_en,	// both grants merged
	output      logic                                      rename1_valid,
	output      prf_pkg::prf_tag_t                         rename1_idx,
	output      logic                                      rename2_valid,
	output      prf_pkg::prf_tag_t                         rename2_idx,
	output      logic                                      prf_full
);

	prf_pkg::prf_vec_t free_vec;	// entries currently on the free list
	prf_pkg::prf_vec_t pick1;	// lowest free entry
	prf_pkg::prf_vec_t pick2;	// second lowest free entry
	prf_pkg::prf_vec_t grant1;
	prf_pkg::prf_vec_t grant2;
	logic              none_free;
	logic              one_left;

	// lowest set bit of a vector as a one hot vector
	function automatic prf_pkg::prf_vec_t pick_lowest(input prf_pkg::prf_vec_t req);
		prf_pkg::prf_vec_t gnt;
		gnt = req & (~req + 1'b1);	// two's complement keeps only the lowest one
		return gnt;
	endfunction

	// one hot vector to entry index, zero for an empty vector
	function automatic prf_pkg::prf_tag_t encode(input prf_pkg::prf_vec_t onehot);
		prf_pkg::prf_tag_t idx;
		idx = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (onehot[i])
				idx = idx | prf_pkg::prf_tag_t'(i);
		end
		return idx;
	endfunction

	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
			free_vec[i] = (entry_state[i] == prf_pkg::PRF_FREE);	// zero tag is never free
	end

	// second picker runs on what is left after the first grant
	assign pick1 = pick_lowest(free_vec);
	assign pick2 = pick_lowest(free_vec & ~pick1);

	assign none_free = (free_vec == '0);
	assign one_left  = (pick1 != '0) && (pick2 == '0);
	assign prf_full  = none_free || (alloc_req1 && alloc_req2 && one_left);

	// request 1 always takes the lower entry, request 2 falls back to the lowest
	// entry when it is alone
	assign grant1 = (alloc_req1 && !prf_full) ? pick1 : '0;
	assign grant2 = (alloc_req2 && !prf_full) ? (alloc_req1 ? pick2 : pick1) : '0;

	assign alloc_en = grant1 | grant2;

	assign rename1_valid = (grant1 != '0);
	assign rename1_idx   = encode(grant1);
	assign rename2_valid = (grant2 != '0);
	assign rename2_idx   = encode(grant2);

endmodule

`default_nettype wire

/* source/prf_operand_read.sv */
//////////////////////////////////////////////////
// operand and retire reads, combinational
// a not ready operand returns its tag with valid low
// retire reads zero for an entry that is not ready
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf_operand_read (
	input  wire prf_pkg::prf_entry_state_e [`PRF_SIZE-1:0] entry_state,
	input  wire prf_pkg::prf_data_t [`PRF_SIZE-1:0]        entry_data,
	input  wire prf_pkg::prf_tag_t                         inst1_opa_idx,
	input  wire prf_pkg::prf_tag_t                         inst1_opb_idx,
	input  wire prf_pkg::prf_tag_t                         inst2_opa_idx,
	input  wire prf_pkg::prf_tag_t                         inst2_opb_idx,
	input  wire prf_pkg::prf_tag_t                         retire_idx,	// retiring instruction
	output      prf_pkg::prf_data_t                        inst1_opa_value,
	output      logic                                      inst1_opa_valid,
	output      prf_pkg::prf_data_t                        inst1_opb_value,
	output      logic                                      inst1_opb_valid,
	output      prf_pkg::prf_data_t                        inst2_opa_value,
	output      logic                                      inst2_opa_valid,
	output      prf_pkg::prf_data_t                        inst2_opb_value,
	output      logic                                      inst2_opb_valid,
	output      prf_pkg::prf_data_t                        retire_value
);

	logic retire_ready;	// retiring entry holds its value

	//////////////////////////////////////////////////
	// operand ports
	//////////////////////////////////////////////////

	// the zero tag entry is held ready at zero in the array, so it needs no special case here
	assign inst1_opa_valid = (entry_state[inst1_opa_idx] == prf_pkg::PRF_READY);
	assign inst1_opb_valid = (entry_state[inst1_opb_idx] == prf_pkg::PRF_READY);
	assign inst2_opa_valid = (entry_state[inst2_opa_idx] == prf_pkg::PRF_READY);
	assign inst2_opb_valid = (entry_state[inst2_opb_idx] == prf_pkg::PRF_READY);

	// while the value is missing the consumer gets the tag to wait on, zero extended
	assign inst1_opa_value = inst1_opa_valid ? entry_data[inst1_opa_idx]
	                                         : prf_pkg::prf_data_t'(inst1_opa_idx);
	assign inst1_opb_value = inst1_opb_valid ? entry_data[inst1_opb_idx]
	                                         : prf_pkg::prf_data_t'(inst1_opb_idx);
	assign inst2_opa_value = inst2_opa_valid ? entry_data[inst2_opa_idx]
	                                         : prf_pkg::prf_data_t'(inst2_opa_idx);
	assign inst2_opb_value = inst2_opb_valid ? entry_data[inst2_opb_idx]
	                                         : prf_pkg::prf_data_t'(inst2_opb_idx);

	//////////////////////////////////////////////////
	// retire port
	//////////////////////////////////////////////////

	assign retire_ready = (entry_state[retire_idx] == prf_pkg::PRF_READY);
	assign retire_value = retire_ready ? entry_data[retire_idx] : '0;	// no tag on this port

endmodule

`default_nettype wire

/* source/prf.sv */
//////////////////////////////////////////////////
// physical register file, single thread
// rename and full are combinational on requests
// writes and frees show from the next cycle
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf (
	input  wire logic               clock,
	input  wire logic               rst_n,
	input  wire logic               cdb1_valid,	// result bus 1
	input  wire prf_pkg::prf_tag_t  cdb1_tag,
	input  wire prf_pkg::prf_data_t cdb1_data,
	input  wire logic               cdb2_valid,	// result bus 2
	input  wire prf_pkg::prf_tag_t  cdb2_tag,
	input  wire prf_pkg::prf_data_t cdb2_data,
	input  wire logic               alloc_req1,
	input  wire logic               alloc_req2,
	input  wire logic               free1_valid,
	input  wire prf_pkg::prf_tag_t  free1_idx,
	input  wire logic               free2_valid,
	input  wire prf_pkg::prf_tag_t  free2_idx,
	input  wire logic               flush_valid,
	input  wire prf_pkg::prf_vec_t  flush_free_list,
	input  wire prf_pkg::prf_tag_t  inst1_opa_idx,
	input  wire prf_pkg::prf_tag_t  inst1_opb_idx,
	input  wire prf_pkg::prf_tag_t  inst2_opa_idx,
	input  wire prf_pkg::prf_tag_t  inst2_opb_idx,
	input  wire prf_pkg::prf_tag_t  retire_idx,
	output      logic               rename1_valid,
	output      prf_pkg::prf_tag_t  rename1_idx,
	output      logic               rename2_valid,
	output      prf_pkg::prf_tag_t  rename2_idx,
	output      logic               prf_full,
	output      prf_pkg::prf_data_t inst1_opa_value,
	output      logic               inst1_opa_valid,
	output      prf_pkg::prf_data_t inst1_opb_value,
	output      logic               inst1_opb_valid,
	output      prf_pkg::prf_data_t inst2_opa_value,
	output      logic               inst2_opa_valid,
	output      prf_pkg::prf_data_t inst2_opb_value,
	output      logic               inst2_opb_valid,
	output      prf_pkg::prf_data_t retire_value
);

	prf_pkg::prf_vec_t                         write_en;	// decoded result writes
	prf_pkg::prf_data_t [`PRF_SIZE-1:0]        write_data;
	prf_pkg::prf_vec_t                         free_en;	// retire frees and flush
	prf_pkg::prf_vec_t                         alloc_en;	// rename grants
	prf_pkg::prf_entry_state_e [`PRF_SIZE-1:0] entry_state;
	prf_pkg::prf_data_t [`PRF_SIZE-1:0]        entry_data;

	prf_write_decode write_decode_i (.cdb1_valid, .cdb1_tag, .cdb1_data, .cdb2_valid, .cdb2_tag,
		.cdb2_data, .free1_valid, .free1_idx, .free2_valid, .free2_idx, .flush_valid,
		.flush_free_list, .write_en, .write_data, .free_en);

	prf_entry_array entry_array_i (.clock, .rst_n, .alloc_en, .write_en, .write_data, .free_en,
		.entry_state, .entry_data);

	prf_free_list free_list_i (.entry_state, .alloc_req1, .alloc_req2, .alloc_en, .rename1_valid,
		.rename1_idx, .rename2_valid, .rename2_idx, .prf_full);

	prf_operand_read operand_read_i (.entry_state, .entry_data, .inst1_opa_idx, .inst1_opb_idx,
		.inst2_opa_idx, .inst2_opb_idx, .retire_idx, .inst1_opa_value, .inst1_opa_valid,
		.inst1_opb_value, .inst1_opb_valid, .inst2_opa_value, .inst2_opa_valid,
		.inst2_opb_value, .inst2_opb_valid, .retire_value);

endmodule

`default_nettype wire

/* testbench/prf_checker.sv */
//////////////////////////////////////////////////
// compares DUT outputs with the expected columns of the current row
// compares on the falling edge, mask bits pick the groups
// bit 0 rename, bit 1 full, bit 2 operands, bit 3 retire
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module prf_checker (
	input  wire logic               clock,
	input  wire logic               active,
	input  wire logic               last_step,
	input  wire logic [36:0][63:0]  step,	// whole stimulus row with expected values
	input  wire logic               rename1_valid,
	input  wire prf_pkg::prf_tag_t  rename1_idx,
	input  wire logic               rename2_valid,
	input  wire prf_pkg::prf_tag_t  rename2_idx,
	input  wire logic               prf_full,
	input  wire prf_pkg::prf_data_t inst1_opa_value,
	input  wire logic               inst1_opa_valid,
	input  wire prf_pkg::prf_data_t inst1_opb_value,
	input  wire logic               inst1_opb_valid,
	input  wire prf_pkg::prf_data_t inst2_opa_value,
	input  wire logic               inst2_opa_valid,
	input  wire prf_pkg::prf_data_t inst2_opb_value,
	input  wire logic               inst2_opb_valid,
	input  wire prf_pkg::prf_data_t retire_value,
	output int                      error_count,
	output int                      tests_passed,
	output int                      tests_failed
);

	int test_errors;	// mismatches in the running test

	initial
	begin
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_errors  = 0;
	end

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)	// catches x as well
		begin
			$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	always @(negedge clock)
	begin
		if (active)
		begin
			if (step[3][0])
			begin
				compare("rename1_valid", step[23], rename1_valid);
				compare("rename1_idx", step[24], rename1_idx);
				compare("rename2_valid", step[25], rename2_valid);
				compare("rename2_idx", step[26], rename2_idx);
			end
			if (step[3][1])
				compare("prf_full", step[27], prf_full);
			if (step[3][2])
			begin
				compare("inst1_opa_valid", step[28], inst1_opa_valid);
				compare("inst1_opa_value", step[29], inst1_opa_value);
				compare("inst1_opb_valid", step[30], inst1_opb_valid);
				compare("inst1_opb_value", step[31], inst1_opb_value);
				compare("inst2_opa_valid", step[32], inst2_opa_valid);
				compare("inst2_opa_value", step[33], inst2_opa_value);
				compare("inst2_opb_valid", step[34], inst2_opb_valid);
				compare("inst2_opb_value", step[35], inst2_opb_value);
			end
			if (step[3][3])
				compare("retire_value", step[36], retire_value);
			if (last_step)
			begin
				if (test_errors == 0)
					tests_passed++;
				else
					tests_failed++;
				$display("test %0d %s", step[0], (test_errors == 0) ? "passed" : "failed");
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/prf_tb.sv */
//////////////////////////////////////////////////
// testbench of the register file, one stimulus row per cycle
// a row with a repeat count is applied that many cycles
// stimulus comes from testbench/prf_stimulus.txt, run from the project root
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "prf_defines.svh"

module prf_tb;

	localparam int NUM_FIELDS = 37;	// columns of one stimulus row
	localparam int MAX_ROWS   = 64;

	logic                             clock;
	logic                             rst_n;
	logic                             active;	// checker compares while high
	logic                             last_step;	// final cycle of a test
	logic [NUM_FIELDS-1:0][63:0]      cur;	// row being applied
	logic [NUM_FIELDS-1:0][63:0]      rows [0:MAX_ROWS-1];
	int                               num_rows;
	int                               total_cycles;
	int                               cycle_limit;
	int                               cycle_count = 0;
	int                               error_count;
	int                               tests_passed;
	int                               tests_failed;
	logic                             rename1_valid;
	prf_pkg::prf_tag_t                rename1_idx;
	logic                             rename2_valid;
	prf_pkg::prf_tag_t                rename2_idx;
	logic                             prf_full;
	prf_pkg::prf_data_t               inst1_opa_value;
	logic                             inst1_opa_valid;
	prf_pkg::prf_data_t               inst1_opb_value;
	logic                             inst1_opb_valid;
	prf_pkg::prf_data_t               inst2_opa_value;
	logic                             inst2_opa_valid;
	prf_pkg::prf_data_t               inst2_opb_value;
	logic                             inst2_opb_valid;
	prf_pkg::prf_data_t               retire_value;

	// column numbers follow the header of the stimulus file
	prf prf_i (.clock, .rst_n, .cdb1_valid(cur[4][0]), .cdb1_tag(cur[5][5:0]),
		.cdb1_data(cur[6]), .cdb2_valid(cur[7][0]), .cdb2_tag(cur[8][5:0]), .cdb2_data(cur[9]),
		.alloc_req1(cur[10][0]), .alloc_req2(cur[11][0]), .free1_valid(cur[12][0]),
		.free1_idx(cur[13][5:0]), .free2_valid(cur[14][0]), .free2_idx(cur[15][5:0]),
		.flush_valid(cur[16][0]), .flush_free_list(cur[17]), .inst1_opa_idx(cur[18][5:0]),
		.inst1_opb_idx(cur[19][5:0]), .inst2_opa_idx(cur[20][5:0]),
		.inst2_opb_idx(cur[21][5:0]), .retire_idx(cur[22][5:0]), .rename1_valid,
		.rename1_idx, .rename2_valid, .rename2_idx, .prf_full, .inst1_opa_value,
		.inst1_opa_valid, .inst1_opb_value, .inst1_opb_valid, .inst2_opa_value,
		.inst2_opa_valid, .inst2_opb_value, .inst2_opb_valid, .retire_value);

	prf_checker checker_i (.clock, .active, .last_step, .step(cur), .rename1_valid, .rename1_idx,
		.rename2_valid, .rename2_idx, .prf_full, .inst1_opa_value, .inst1_opa_valid,
		.inst1_opb_value, .inst1_opb_valid, .inst2_opa_value, .inst2_opa_valid,
		.inst2_opb_value, .inst2_opb_valid, .retire_value, .error_count, .tests_passed,
		.tests_failed);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;	// 100 ns period
	end

	// ends a run that hangs, the limit is set once the file is loaded
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("run stopped after %0d cycles, the stimulus did not finish", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	initial
	begin
		int          fd;
		int          n;
		int          got;
		logic        load_ok;
		string       line;
		logic [63:0] f [0:NUM_FIELDS-1];
		rst_n        = 1'b0;
		active       = 1'b0;
		last_step    = 1'b0;
		cur          = '0;	// every DUT input starts at zero
		num_rows     = 0;
		total_cycles = 0;
		cycle_limit  = 0;
		load_ok      = 1'b1;
		fd = $fopen("testbench/prf_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("stimulus file testbench/prf_stimulus.txt could not be opened");
			load_ok = 1'b0;
		end
		else
		begin
			while (!$feof(fd) && load_ok)
			begin
				// a comment line does not start with a hex number
				n = $fscanf(fd, "%h", f[0]);
				if (n == 1)
				begin
					for (int k = 1; k < NUM_FIELDS; k++)
					begin
						got = $fscanf(fd, "%h", f[k]);
						if (got == 1)
							n++;
					end
					if (n == NUM_FIELDS && num_rows < MAX_ROWS)
					begin
						for (int k = 0; k < NUM_FIELDS; k++)
							rows[num_rows][k] = f[k];
						total_cycles += int'(f[2]);
						num_rows++;
					end
					else
					begin
						$display("stimulus row %0d is malformed or one too many", num_rows + 1);
						load_ok = 1'b0;
					end
				end
				else if (n == 0)
					void'($fgets(line, fd));	// rest of a comment line
			end
			$fclose(fd);
			if (load_ok && num_rows == 0)
			begin
				$display("stimulus file holds no rows");
				load_ok = 1'b0;
			end
		end
		cycle_limit = 2 * total_cycles + 20;
		if (!load_ok)
		begin
			$display("Checks failed");
			$finish;
		end
		else
		begin
			repeat (3) @(posedge clock);	// reset held for three edges
			#1 rst_n = 1'b1;
			for (int r = 0; r < num_rows; r++)
			begin
				for (int k = 0; k < int'(rows[r][2]); k++)
				begin
					@(posedge clock);
					#1;
					cur       = rows[r];
					last_step = rows[r][1][0] && (k == int'(rows[r][2]) - 1);
					active    = 1'b1;
				end
			end
			@(posedge clock);
			#1 active = 1'b0;
			$display("%0d tests passed, %0d tests failed, %0d mismatches", tests_passed,
				tests_failed, error_count);
			if (error_count == 0 && tests_failed == 0)
				$display("All checks passed");
			else
				$display("Checks failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* testbench/prf_stimulus.txt */
# all columns hex: test last rep mask | c1v c1tag c1data c2v c2tag c2data req1 req2
# f1v f1idx f2v f2idx flv flushlist opa1 opb1 opa2 opb2 retidx | expected:
# r1v r1idx r2v r2idx full a1v a1 b1v b1 a2v a2 b2v b2 retval
1 0 1 f 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 30 1 0 1 1 0 1 0 1 0 1 0 1 0 0
1 1 1 f 0 0 0 0 0 0 1 0 0 0 0 0 0 0 30 30 30 30 30 1 2 0 0 0 1 0 1 0 1 0 1 0 0
2 0 1 f 1 2 1111 0 0 0 0 0 0 0 0 0 0 0 2 30 30 30 30 0 0 0 0 0 0 2 1 0 1 0 1 0 0
2 1 1 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 30 30 30 30 0 0 0 0 0 1 1111 1 0 1 0 1 0 0
3 0 1 f 1 0 aaaa 1 1 bbbb 0 0 0 0 0 0 0 0 0 1 30 30 30 0 0 0 0 0 0 0 0 1 1 0 1 0 0
3 0 1 f 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 1 30 30 30 1 3 0 0 0 1 aaaa 1 bbbb 1 0 1 0 0
3 0 1 f 1 3 1 1 3 2222 0 0 0 0 0 0 0 0 30 30 3 30 30 0 0 0 0 0 1 0 1 0 0 3 1 0 0
3 0 1 f 1 a ffff 0 0 0 0 0 0 0 0 0 0 0 30 30 3 30 30 0 0 0 0 0 1 0 1 0 1 2222 1 0 0
3 1 1 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 30 30 30 a 30 0 0 0 0 0 1 0 1 0 1 0 0 a 0
4 0 1 f 0 0 0 0 0 0 0 0 1 0 1 1 0 0 30 30 30 30 0 0 0 0 0 0 1 0 1 0 1 0 1 0 aaaa
4 0 1 f 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 2 1 0 1 1 0 1 0 1 0 1 0 1 0 1111
4 1 1 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 30 30 30 0 0 0 0 0 0 0 0 1 0 1 0 1 0 0
5 0 16 6 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 30 0 0 0 0 0 1 0 1 0 1 0 1 0 0
5 0 1 f 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 30 1 31 1 32 0 1 0 1 0 1 0 1 0 0
5 0 6 6 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 30 0 0 0 0 0 1 0 1 0 1 0 1 0 0
5 0 1 f 0 0 0 0 0 0 1 1 0 0 0 0 0 0 30 30 30 30 30 0 0 0 0 1 1 0 1 0 1 0 1 0 0
5 0 1 f 0 0 0 0 0 0 0 1 0 0 0 0 0 0 30 30 30 30 30 0 0 1 3f 0 1 0 1 0 1 0 1 0 0
5 1 1 f 0 0 0 0 0 0 1 0 0 0 0 0 0 0 30 30 30 30 30 0 0 0 0 1 1 0 1 0 1 0 1 0 0
6 0 1 f 0 0 0 0 0 0 0 0 0 0 0 0 1 fffeffffffffffff 3 30 30 30 30 0 0 0 0 1 1 2222 1 0 1 0 1 0 0
6 1 1 f 0 0 0 0 0 0 1 1 0 0 0 0 0 0 3 30 30 30 30 1 0 1 1 0 0 3 1 0 1 0 1 0 0

/* sources.f */
+incdir+source
source/prf_pkg.sv
source/prf_write_decode.sv
source/prf_entry_array.sv
source/prf_free_list.sv
source/prf_operand_read.sv
source/prf.sv
testbench/prf_checker.sv
testbench/prf_tb.sv

/* Bender.yml */
package:
  name: prf

export_include_dirs:
  - source

sources:
  - files:
      - source/prf_pkg.sv
      - source/prf_write_decode.sv
      - source/prf_entry_array.sv
      - source/prf_free_list.sv
      - source/prf_operand_read.sv
      - source/prf.sv
  - target: simulation
    files:
      - testbench/prf_checker.sv
      - testbench/prf_tb.sv
